//--- design/data_ram.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module data_ram (
    input  logic                clk,
    input  logic                we_i,
    input  logic                re_i,
    input  mem_pkg::ram_index_t index_i,
    input  mem_pkg::byte_en_t   byte_en_i,
    input  mem_pkg::word_t      wdata_i,
    output mem_pkg::word_t      rdata_o
);

    mem_pkg::word_t mem [`RAM_WORDS];

    initial begin
        for (int i = 0; i < `RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // per-lane write
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (we_i && byte_en_i[b]) begin
                mem[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
    end

    // read word held until the next access
    always_ff @(posedge clk) begin
        if (re_i) begin
            rdata_o <= mem[index_i];
        end
    end

endmodule

//--- design/load_align.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module load_align (
    input  mem_pkg::aluop_t aluop_i,
    input  logic [1:0]      addr_lo_i,
    input  mem_pkg::word_t  rdata_i,
    input  mem_pkg::word_t  result_i,
    output mem_pkg::word_t  data_o
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // addressed byte and half of the read word
    always_comb begin
        case (addr_lo_i)
            2'b00:   byte_lane = rdata_i[7:0];
            2'b01:   byte_lane = rdata_i[15:8];
            2'b10:   byte_lane = rdata_i[23:16];
            default: byte_lane = rdata_i[31:24];
        endcase
        half_lane = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];
    end

    always_comb begin
        case (aluop_i)
            `ALU_LDB: begin
                data_o = {{24{byte_lane[7]}}, byte_lane};
            end
            `ALU_LDBU: begin
                data_o = {24'b0, byte_lane};
            end
            `ALU_LDH: begin
                data_o = {{16{half_lane[15]}}, half_lane};
            end
            `ALU_LDHU: begin
                data_o = {16'b0, half_lane};
            end
            `ALU_LDW: begin
                data_o = rdata_i;
            end
            default: begin
                // stores and alu ops write back the alu result
                data_o = result_i;
            end
        endcase
    end

endmodule

//--- design/mem_access_prep.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_access_prep (
    input  mem_pkg::aluop_t   aluop_i,
    input  mem_pkg::word_t    addr_i,
    input  mem_pkg::word_t    store_data_i,
    output logic              is_load_o,
    output logic              is_store_o,
    output logic              misalign_o,
    output mem_pkg::byte_en_t byte_en_o,
    output mem_pkg::word_t    wdata_o
);

    always_comb begin
        is_load_o  = 1'b0;
        is_store_o = 1'b0;
        misalign_o = 1'b0;
        byte_en_o  = '0;
        wdata_o    = '0;
        case (aluop_i)
            `ALU_LDB, `ALU_LDBU: begin
                is_load_o = 1'b1;
            end
            `ALU_LDH, `ALU_LDHU: begin
                is_load_o  = 1'b1;
                misalign_o = addr_i[0];
            end
            `ALU_LDW: begin
                is_load_o  = 1'b1;
                misalign_o = |addr_i[1:0];
            end
            `ALU_STB: begin
                is_store_o = 1'b1;
                wdata_o    = {4{store_data_i[7:0]}};
                byte_en_o  = 4'b0001 << addr_i[1:0];
            end
            `ALU_STH: begin
                is_store_o = 1'b1;
                misalign_o = addr_i[0];
                wdata_o    = {2{store_data_i[15:0]}};
                byte_en_o  = addr_i[1] ? 4'b1100 : 4'b0011;
            end
            `ALU_STW: begin
                is_store_o = 1'b1;
                misalign_o = |addr_i[1:0];
                wdata_o    = store_data_i;
                byte_en_o  = 4'b1111;
            end
            default: begin
                // alu ops leave memory alone
                wdata_o = '0;
            end
        endcase
    end

    // strobe lanes only for stores
    always_comb begin
        if (!is_store_o) begin
            assert (byte_en_o == '0)
                else $error("byte strobe set for a non-store op %h", aluop_i);
        end
    end

endmodule

//--- design/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// non-memory op
`define ALU_ADD      8'h01

// loads
`define ALU_LDB      8'h20
`define ALU_LDBU     8'h21
`define ALU_LDH      8'h22
`define ALU_LDHU     8'h23
`define ALU_LDW      8'h24

// stores
`define ALU_STB      8'h28
`define ALU_STH      8'h29
`define ALU_STW      8'h2a

// address error exception
`define ECODE_ALE    6'h09

// timer cycles, selected by address bit 31
`define LAT_CACHED   3'd1
`define LAT_UNCACHED 3'd4

`define RAM_WORDS    256

`endif

//--- design/mem_ctrl_fsm.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_ctrl_fsm (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 in_valid_i,
    input  logic                 misalign_i,
    input  logic                 is_load_i,
    input  logic                 is_store_i,
    input  logic                 timer_done_i,
    input  logic                 out_ready_i,
    input  mem_pkg::aluop_t      aluop_i,
    input  mem_pkg::word_t       addr_i,
    input  mem_pkg::word_t       alu_result_i,
    input  mem_pkg::word_t       pc_i,
    input  mem_pkg::reg_addr_t   rd_i,
    input  logic                 rd_we_i,
    output logic                 in_ready_o,
    output logic                 mem_strobe_o,
    output logic                 timer_start_o,
    output mem_pkg::lat_count_t  timer_count_o,
    output mem_pkg::aluop_t      held_aluop_o,
    output mem_pkg::word_t       held_addr_o,
    output mem_pkg::word_t       held_result_o,
    output logic                 out_valid_o,
    output logic                 wb_we_o,
    output mem_pkg::reg_addr_t   wb_rd_o,
    output mem_pkg::word_t       wb_pc_o,
    output logic                 excp_o,
    output mem_pkg::ecode_t      ecode_o
);

    mem_pkg::ctrl_state_t state;
    logic                 accept;
    logic                 held_rd_we;

    assign in_ready_o    = (state == mem_pkg::ST_IDLE);
    assign accept        = in_valid_i && in_ready_o;
    assign mem_strobe_o  = accept && (is_load_i || is_store_i) && !misalign_i;
    assign timer_start_o = mem_strobe_o;
    // bit 31 marks the uncached window
    assign timer_count_o = addr_i[31] ? `LAT_UNCACHED : `LAT_CACHED;
    assign wb_we_o       = held_rd_we && !excp_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= mem_pkg::ST_IDLE;
            out_valid_o <= 1'b0;
            excp_o      <= 1'b0;
        end else begin
            case (state)
                mem_pkg::ST_IDLE: begin
                    if (accept) begin
                        excp_o <= misalign_i;
                        if (mem_strobe_o) begin
                            state <= mem_pkg::ST_ACCESS;
                        end else begin
                            state <= mem_pkg::ST_DONE;
                        end
                    end
                end
                mem_pkg::ST_ACCESS: begin
                    if (timer_done_i) begin
                        state       <= mem_pkg::ST_DONE;
                        out_valid_o <= 1'b1;
                    end
                end
                default: begin
                    if (!out_valid_o) begin
                        // alu ops and address errors are valid one edge after accept
                        out_valid_o <= 1'b1;
                    end else if (out_ready_i) begin
                        state       <= mem_pkg::ST_IDLE;
                        out_valid_o <= 1'b0;
                    end
                end
            endcase
        end
    end

    // instruction fields captured on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            held_aluop_o  <= aluop_i;
            held_addr_o   <= addr_i;
            held_result_o <= alu_result_i;
            held_rd_we    <= rd_we_i;
            wb_rd_o       <= rd_i;
            wb_pc_o       <= pc_i;
            ecode_o       <= misalign_i ? `ECODE_ALE : 6'h00;
        end
    end

    assert property (@(posedge clk) disable iff (reset_i)
        out_valid_o |-> (state == mem_pkg::ST_DONE))
        else $error("out_valid_o high outside ST_DONE");

    // write-back side must hold still while stalled
    assert property (@(posedge clk) disable iff (reset_i)
        (out_valid_o && !out_ready_i) |=> out_valid_o && $stable({held_aluop_o,
            held_addr_o, held_result_o, wb_we_o, wb_rd_o, wb_pc_o, excp_o, ecode_o}))
        else $error("held outputs changed under back-pressure");

endmodule

//--- design/mem_latency_timer.sv
`timescale 1ns/1ps

module mem_latency_timer (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                start_i,
    input  mem_pkg::lat_count_t count_i,
    output logic                done_o
);

    mem_pkg::lat_count_t cnt;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt    <= '0;
            done_o <= 1'b0;
        end else if (start_i) begin
            cnt    <= count_i;
            done_o <= 1'b0;
        end else if (cnt != '0) begin
            cnt    <= cnt - 1'b1;
            // last step of the count
            done_o <= (cnt == 3'd1);
        end else begin
            done_o <= 1'b0;
        end
    end

    // the FSM may only launch an access once the previous one is over
    assert property (@(posedge clk) disable iff (reset_i) start_i |-> (cnt == '0))
        else $error("timer restarted while a count was running");

endmodule

//--- design/mem_pkg.sv
package mem_pkg;

    // data and address words
    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_addr_t;

    typedef logic [7:0] aluop_t;

    // one strobe bit per byte lane
    typedef logic [3:0] byte_en_t;

    typedef logic [5:0] ecode_t;

    // word index into the data memory
    typedef logic [7:0] ram_index_t;

    typedef logic [2:0] lat_count_t;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ACCESS = 2'd1,
        ST_DONE   = 2'd2
    } ctrl_state_t;

endpackage

//--- design/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top (
    input  logic               clk,
    input  logic               reset_i,
    // execute side
    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  mem_pkg::aluop_t    aluop_i,
    input  mem_pkg::word_t     addr_i,
    input  mem_pkg::word_t     store_data_i,
    input  mem_pkg::word_t     alu_result_i,
    input  mem_pkg::reg_addr_t rd_i,
    input  logic               rd_we_i,
    input  mem_pkg::word_t     pc_i,
    // write-back side
    output logic               out_valid_o,
    input  logic               out_ready_i,
    output logic               wb_we_o,
    output mem_pkg::reg_addr_t wb_rd_o,
    output mem_pkg::word_t     wb_data_o,
    output mem_pkg::word_t     wb_pc_o,
    output logic               excp_o,
    output mem_pkg::ecode_t    ecode_o
);

    logic                is_load;
    logic                is_store;
    logic                misalign;
    logic                mem_strobe;
    logic                timer_start;
    logic                timer_done;
    mem_pkg::lat_count_t timer_count;
    mem_pkg::byte_en_t   byte_en;
    mem_pkg::word_t      wdata;
    mem_pkg::word_t      rdata;
    mem_pkg::aluop_t     held_aluop;
    mem_pkg::word_t      held_addr;
    mem_pkg::word_t      held_result;

    mem_ctrl_fsm ctrl_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .in_valid_i    (in_valid_i),
        .misalign_i    (misalign),
        .is_load_i     (is_load),
        .is_store_i    (is_store),
        .timer_done_i  (timer_done),
        .out_ready_i   (out_ready_i),
        .aluop_i       (aluop_i),
        .addr_i        (addr_i),
        .alu_result_i  (alu_result_i),
        .pc_i          (pc_i),
        .rd_i          (rd_i),
        .rd_we_i       (rd_we_i),
        .in_ready_o    (in_ready_o),
        .mem_strobe_o  (mem_strobe),
        .timer_start_o (timer_start),
        .timer_count_o (timer_count),
        .held_aluop_o  (held_aluop),
        .held_addr_o   (held_addr),
        .held_result_o (held_result),
        .out_valid_o   (out_valid_o),
        .wb_we_o       (wb_we_o),
        .wb_rd_o       (wb_rd_o),
        .wb_pc_o       (wb_pc_o),
        .excp_o        (excp_o),
        .ecode_o       (ecode_o)
    );

    mem_latency_timer timer_i (
        .clk     (clk),
        .reset_i (reset_i),
        .start_i (timer_start),
        .count_i (timer_count),
        .done_o  (timer_done)
    );

    mem_access_prep prep_i (
        .aluop_i      (aluop_i),
        .addr_i       (addr_i),
        .store_data_i (store_data_i),
        .is_load_o    (is_load),
        .is_store_o   (is_store),
        .misalign_o   (misalign),
        .byte_en_o    (byte_en),
        .wdata_o      (wdata)
    );

    // loads carry a zero strobe, so one pulse serves read and write
    data_ram ram_i (
        .clk       (clk),
        .we_i      (mem_strobe),
        .re_i      (mem_strobe),
        .index_i   (addr_i[9:2]),
        .byte_en_i (byte_en),
        .wdata_i   (wdata),
        .rdata_o   (rdata)
    );

    load_align align_i (
        .aluop_i   (held_aluop),
        .addr_lo_i (held_addr[1:0]),
        .rdata_i   (rdata),
        .result_i  (held_result),
        .data_o    (wb_data_o)
    );

endmodule

//--- mem_stage_top.f
+incdir+design
design/mem_pkg.sv
design/mem_access_prep.sv
design/load_align.sv
design/data_ram.sv
design/mem_latency_timer.sv
design/mem_ctrl_fsm.sv
design/mem_stage_top.sv
sim/mem_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module mem_stage_tb \
    -f mem_stage_top.f -o mem_stage_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/mem_stage_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TEST OK"; then
    exit 0
fi
exit 1

//--- sim/mem_stage_tb.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_stage_tb;

    localparam int N_STORES   = 24;
    localparam int N_WORDS    = 16;
    localparam int N_NARROW   = 4 * 13;
    localparam int N_MISALIGN = 11;
    localparam int N_ALU      = 8;
    localparam int N_UNCACHED = 8;
    localparam int N_INSTR    = N_STORES + N_WORDS + N_NARROW + N_MISALIGN + N_ALU + N_UNCACHED;
    localparam int MAX_STALL  = 3;
    // accept wait, worst latency, longest stall run and the transfer edge
    localparam int CYCLES_PER = 3 + 1 + `LAT_UNCACHED + MAX_STALL;
    localparam int TIMEOUT    = 10 + N_INSTR * CYCLES_PER;

    typedef struct packed {
        mem_pkg::word_t     data;
        logic               we;
        logic               excp;
        mem_pkg::ecode_t    ecode;
        mem_pkg::reg_addr_t rd;
        mem_pkg::word_t     pc;
        logic [31:0]        edges;
        logic [31:0]        accept_cycle;
    } expect_t;

    logic               clk;
    logic               reset_i;
    logic               in_valid_i;
    logic               in_ready_o;
    mem_pkg::aluop_t    aluop_i;
    mem_pkg::word_t     addr_i;
    mem_pkg::word_t     store_data_i;
    mem_pkg::word_t     alu_result_i;
    mem_pkg::reg_addr_t rd_i;
    logic               rd_we_i;
    mem_pkg::word_t     pc_i;
    logic               out_valid_o;
    logic               out_ready_i;
    logic               wb_we_o;
    mem_pkg::reg_addr_t wb_rd_o;
    mem_pkg::word_t     wb_data_o;
    mem_pkg::word_t     wb_pc_o;
    logic               excp_o;
    mem_pkg::ecode_t    ecode_o;

    mem_pkg::word_t shadow [`RAM_WORDS];
    expect_t        exp_q[$];
    string          name_q[$];
    expect_t        cur;
    logic [31:0]    cycle_cnt;
    int             stall_run;
    logic           valid_seen;

    mem_stage_top dut_i (.*);

    always #50 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input mem_pkg::word_t exp,
            input mem_pkg::word_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_ecode(input string name, input mem_pkg::ecode_t exp,
            input mem_pkg::ecode_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
        end
    endtask

    function automatic mem_pkg::word_t make_addr(input int idx, input int off, input logic unc);
        return {unc, 21'h0, idx[7:0], off[1:0]};
    endfunction

    // expected write-back for one instruction against the shadow memory
    function automatic void ref_result(input mem_pkg::aluop_t op, input mem_pkg::word_t addr,
            input mem_pkg::word_t result, input logic rd_we, output expect_t e);
        mem_pkg::word_t w;
        logic [7:0]     b;
        logic [15:0]    h;
        logic           is_mem;
        logic           mis;
        e      = '0;
        w      = shadow[addr[9:2]];
        b      = w[8*addr[1:0] +: 8];
        h      = w[16*addr[1] +: 16];
        is_mem = op inside {`ALU_LDB, `ALU_LDBU, `ALU_LDH, `ALU_LDHU, `ALU_LDW,
                            `ALU_STB, `ALU_STH, `ALU_STW};
        if (op inside {`ALU_LDH, `ALU_LDHU, `ALU_STH}) begin
            mis = addr[0];
        end else if (op inside {`ALU_LDW, `ALU_STW}) begin
            mis = |addr[1:0];
        end else begin
            mis = 1'b0;
        end
        case (op)
            `ALU_LDB:  e.data = {{24{b[7]}}, b};
            `ALU_LDBU: e.data = {24'b0, b};
            `ALU_LDH:  e.data = {{16{h[15]}}, h};
            `ALU_LDHU: e.data = {16'b0, h};
            `ALU_LDW:  e.data = w;
            default:   e.data = result;
        endcase
        e.we    = rd_we && !mis;
        e.excp  = mis;
        e.ecode = mis ? `ECODE_ALE : 6'h00;
        // alu ops and address errors are valid one edge after accept
        e.edges = (is_mem && !mis) ? 32'(1 + (addr[31] ? `LAT_UNCACHED : `LAT_CACHED)) : 32'd1;
    endfunction

    function automatic void apply_store(input mem_pkg::aluop_t op, input mem_pkg::word_t addr,
            input mem_pkg::word_t sdata);
        case (op)
            `ALU_STB: shadow[addr[9:2]][8*addr[1:0] +: 8]  = sdata[7:0];
            `ALU_STH: shadow[addr[9:2]][16*addr[1] +: 16] = sdata[15:0];
            `ALU_STW: shadow[addr[9:2]] = sdata;
            default: ;
        endcase
    endfunction

    task automatic issue_instr(input string name, input mem_pkg::aluop_t op,
            input mem_pkg::word_t addr, input mem_pkg::word_t sdata, input logic rd_we);
        expect_t        e;
        mem_pkg::word_t result;
        result = $urandom;
        ref_result(op, addr, result, rd_we, e);
        e.rd = 5'($urandom);
        e.pc = $urandom;
        if (!e.excp) begin
            apply_store(op, addr, sdata);
        end
        in_valid_i   = 1'b1;
        aluop_i      = op;
        addr_i       = addr;
        store_data_i = sdata;
        alu_result_i = result;
        rd_i         = e.rd;
        rd_we_i      = rd_we;
        pc_i         = e.pc;
        while (!in_ready_o) @(negedge clk);
        // taken on the next rising edge
        e.accept_cycle = cycle_cnt + 1;
        exp_q.push_back(e);
        name_q.push_back(name);
        @(negedge clk);
        in_valid_i = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT) begin
            abort_run($sformatf("run hung, %0d results still missing after %0d cycles",
                exp_q.size(), cycle_cnt));
        end
    end

    // write-back monitor with random back-pressure
    always @(negedge clk) begin
        if (!reset_i) begin
            if (out_valid_o) begin
                if (exp_q.size() == 0) begin
                    abort_run("write-back valid with no instruction pending");
                end
                cur = exp_q[0];
                if (!valid_seen) begin
                    check_word({name_q[0], " valid latency"}, cur.edges,
                        cycle_cnt - cur.accept_cycle);
                    valid_seen = 1'b1;
                end
                check_flag({name_q[0], " in_ready while held"}, 1'b0, in_ready_o);
                check_flag({name_q[0], " excp"}, cur.excp, excp_o);
                check_ecode({name_q[0], " ecode"}, cur.ecode, ecode_o);
                check_flag({name_q[0], " wb_we"}, cur.we, wb_we_o);
                check_word({name_q[0], " wb_rd"}, 32'(cur.rd), 32'(wb_rd_o));
                check_word({name_q[0], " wb_pc"}, cur.pc, wb_pc_o);
                if (!cur.excp) begin
                    check_word({name_q[0], " wb_data"}, cur.data, wb_data_o);
                end
            end
            if (stall_run >= MAX_STALL || ($urandom % 3) != 0) begin
                out_ready_i = 1'b1;
                stall_run   = 0;
            end else begin
                out_ready_i = 1'b0;
                stall_run++;
            end
            if (out_valid_o && out_ready_i) begin
                void'(exp_q.pop_front());
                void'(name_q.pop_front());
                valid_seen = 1'b0;
            end
        end
    end

    initial begin
        mem_pkg::aluop_t op;
        mem_pkg::word_t  data;
        int              idx;
        int              off;
        int              sel;
        void'($urandom(32'hb4ba_d494));
        clk          = 1'b0;
        reset_i      = 1'b1;
        in_valid_i   = 1'b0;
        aluop_i      = `ALU_ADD;
        addr_i       = '0;
        store_data_i = '0;
        alu_result_i = '0;
        rd_i         = '0;
        rd_we_i      = 1'b0;
        pc_i         = '0;
        out_ready_i  = 1'b0;
        cycle_cnt    = '0;
        stall_run    = 0;
        valid_seen   = 1'b0;
        for (int i = 0; i < `RAM_WORDS; i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        check_flag("reset in_ready", 1'b1, in_ready_o);
        check_flag("reset out_valid", 1'b0, out_valid_o);
        check_flag("reset excp", 1'b0, excp_o);

        // random stores of every width followed by whole-word readback
        for (int i = 0; i < N_STORES; i++) begin
            idx = $urandom % N_WORDS;
            sel = $urandom % 3;
            op  = (sel == 0) ? `ALU_STB : (sel == 1) ? `ALU_STH : `ALU_STW;
            off = (sel == 0) ? $urandom % 4 : (sel == 1) ? 2 * ($urandom % 2) : 0;
            issue_instr($sformatf("store op %h offset %0d", op, off), op,
                make_addr(idx, off, 1'b0), $urandom, 1'b0);
        end
        for (idx = 0; idx < N_WORDS; idx++) begin
            issue_instr($sformatf("ld.w word %0d", idx), `ALU_LDW, make_addr(idx, 0, 1'b0),
                '0, 1'b1);
        end

        // odd words of the narrow loads carry set sign bits in every lane
        for (int w = 0; w < 4; w++) begin
            idx  = 32 + w;
            data = w[0] ? ($urandom | 32'h8080_8080) : ($urandom & 32'h7f7f_7f7f);
            issue_instr("narrow setup st.w", `ALU_STW, make_addr(idx, 0, 1'b0), data, 1'b0);
            for (off = 0; off < 4; off++) begin
                issue_instr($sformatf("ld.b offset %0d", off), `ALU_LDB,
                    make_addr(idx, off, 1'b0), '0, 1'b1);
                issue_instr($sformatf("ld.bu offset %0d", off), `ALU_LDBU,
                    make_addr(idx, off, 1'b0), '0, 1'b1);
            end
            for (off = 0; off < 4; off += 2) begin
                issue_instr($sformatf("ld.h offset %0d", off), `ALU_LDH,
                    make_addr(idx, off, 1'b0), '0, 1'b1);
                issue_instr($sformatf("ld.hu offset %0d", off), `ALU_LDHU,
                    make_addr(idx, off, 1'b0), '0, 1'b1);
            end
        end

        // address errors leave the word untouched
        idx = 48;
        issue_instr("misalign setup st.w", `ALU_STW, make_addr(idx, 0, 1'b0), $urandom, 1'b0);
        issue_instr("ld.h offset 1", `ALU_LDH, make_addr(idx, 1, 1'b0), '0, 1'b1);
        issue_instr("ld.h offset 3", `ALU_LDH, make_addr(idx, 3, 1'b0), '0, 1'b1);
        issue_instr("ld.hu offset 1", `ALU_LDHU, make_addr(idx, 1, 1'b0), '0, 1'b1);
        for (off = 1; off < 4; off++) begin
            issue_instr($sformatf("ld.w offset %0d", off), `ALU_LDW,
                make_addr(idx, off, 1'b0), '0, 1'b1);
        end
        issue_instr("st.h offset 1", `ALU_STH, make_addr(idx, 1, 1'b0), $urandom, 1'b1);
        issue_instr("st.h offset 3", `ALU_STH, make_addr(idx, 3, 1'b0), $urandom, 1'b1);
        issue_instr("st.w offset 2", `ALU_STW, make_addr(idx, 2, 1'b0), $urandom, 1'b1);
        issue_instr("ld.w after misalign", `ALU_LDW, make_addr(idx, 0, 1'b0), '0, 1'b1);

        for (int i = 0; i < N_ALU; i++) begin
            issue_instr("add pass-through", `ALU_ADD, $urandom, $urandom, 1'b1);
        end

        // bit 31 aliases the same words with the long latency
        for (idx = 0; idx < N_UNCACHED; idx++) begin
            issue_instr($sformatf("uncached ld.w word %0d", idx), `ALU_LDW,
                make_addr(idx, 0, 1'b1), '0, 1'b1);
        end

        while (exp_q.size() != 0) @(negedge clk);
        @(negedge clk);
        check_flag("out_valid after last transfer", 1'b0, out_valid_o);
        $display("TEST OK");
        $finish;
    end

endmodule
